//--- common/ex_pkg.sv
package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////////////////////////

  localparam int WORD_W     = 32;
  localparam int MULT_STEPS = 32; // One shift-add per multiplier bit
  localparam int DOT_LANES  = 4;
  localparam int LANE_W     = 8;
  localparam int N_WSPR     = 4;  // Weight registers
  localparam int N_ASPR     = 2;  // Activation registers

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [5:0]        reg_addr_t;
  typedef logic [5:0]        step_cnt_t;
  typedef logic [1:0]        wspr_idx_t;
  typedef logic              aspr_idx_t;

  ////////////////////////////////////////////////////////////
  // Operator and state encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic {
    MULT_MAC,  // a * b + c, multi-cycle
    MULT_DOT8  // 4x8-bit signed dot product + c
  } mult_op_e;

  typedef enum logic [1:0] {
    MULT_IDLE = 2'b00,
    MULT_BUSY = 2'b01,
    MULT_DONE = 2'b10
  } mult_state_e;

endpackage

//--- rtl/ex_alu.sv
module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  logic [4:0] shamt;
  logic       cmp;

  assign shamt = operand_b_i[4:0]; // Only low 5 bits matter

  // Comparator shared by set-less-than and branches
  always_comb begin
    unique case (operator_i)
      ALU_SLT, ALU_LT:  cmp = $signed(operand_a_i) < $signed(operand_b_i);
      ALU_SLTU, ALU_LTU: cmp = operand_a_i < operand_b_i;
      ALU_EQ:           cmp = operand_a_i == operand_b_i;
      ALU_NE:           cmp = operand_a_i != operand_b_i;
      ALU_GE:           cmp = $signed(operand_a_i) >= $signed(operand_b_i);
      ALU_GEU:          cmp = operand_a_i >= operand_b_i;
      default:          cmp = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp;

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      default: result_o = {{(WORD_W-1){1'b0}}, cmp}; // Comparisons zero-extended
    endcase
  end

endmodule

//--- mult/mult_ctrl.sv
module mult_ctrl import ex_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic count_done_i,
  input  logic ex_ready_i,
  output logic load_o,
  output logic step_o,
  output logic ready_o,
  output logic multicycle_o
);

  mult_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_IDLE: if (start_i) state_d = MULT_BUSY;
      MULT_BUSY: if (count_done_i) state_d = MULT_DONE;
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE; // Result consumed
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Load on the edge that samples the start
  assign load_o = (state_q == MULT_IDLE) & start_i;
  assign step_o = (state_q == MULT_BUSY);

  // Ready when nothing to do or result waiting
  assign ready_o = ((state_q == MULT_IDLE) & ~start_i) | (state_q == MULT_DONE);

  assign multicycle_o = (state_q == MULT_BUSY) | (state_q == MULT_DONE);

endmodule

//--- mult/mult_counter.sv
module mult_counter import ex_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic load_i,
  input  logic step_i,
  output logic done_o
);

  step_cnt_t cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= step_cnt_t'(MULT_STEPS);
    end else if (step_i) begin
      cnt_q <= cnt_q - step_cnt_t'(1); // One per shift-add
    end
  end

  // Final step runs with the count at zero
  assign done_o = step_i & (cnt_q == '0);

endmodule

//--- mult/mult_datapath.sv
module mult_datapath import ex_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_i,
  input  logic  step_i,
  input  word_t op_a_i,
  input  word_t op_b_i,
  input  word_t op_c_i,
  output word_t result_o
);

  word_t acc_q;    // Running sum, starts at c
  word_t mcand_q;  // a, shifted left each step
  word_t mplier_q; // b, shifted right each step
  word_t acc_add;

  // Partial product only when the current multiplier bit is set
  assign acc_add = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  ////////////////////////////////////////////////////////////
  // Shift-add registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q    <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
    end else if (load_i) begin
      acc_q    <= op_c_i;
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
    end else if (step_i) begin
      acc_q    <= acc_add;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1; // Zero once all bits are used
    end
  end

  // Low 32 bits of a*b + c once the steps are done
  assign result_o = acc_q;

endmodule

//--- rtl/dot_unit.sv
module dot_unit import ex_pkg::*; (
  input  logic  use_spr_i,
  input  word_t op_a_i,
  input  word_t op_b_i,
  input  word_t op_c_i,
  input  word_t wspr_i,
  input  word_t aspr_i,
  output word_t result_o
);

  word_t op_a;
  word_t op_b;

  // Weights on a, activations on b
  assign op_a = use_spr_i ? wspr_i : op_a_i;
  assign op_b = use_spr_i ? aspr_i : op_b_i;

  always_comb begin
    logic signed [LANE_W-1:0]   lane_a;
    logic signed [LANE_W-1:0]   lane_b;
    logic signed [2*LANE_W-1:0] prod;
    word_t                      sum;
    sum = op_c_i;
    for (int i = 0; i < DOT_LANES; i++) begin
      lane_a = op_a[i*LANE_W +: LANE_W];
      lane_b = op_b[i*LANE_W +: LANE_W];
      prod   = lane_a * lane_b;
      sum    = sum + word_t'(signed'(prod)); // Sign-extend lane product
    end
    result_o = sum; // Wraps at 32 bits
  end

endmodule

//--- rtl/rnn_spr_file.sv
module rnn_spr_file import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  wspr_idx_t wspr_rd_idx_i,
  input  aspr_idx_t aspr_rd_idx_i,
  input  logic      wspr_we_i,
  input  logic      aspr_we_i,
  input  wspr_idx_t wspr_wr_idx_i,
  input  aspr_idx_t aspr_wr_idx_i,
  input  word_t     wdata_i,
  output word_t     wspr_o,
  output word_t     aspr_o
);

  word_t wspr_q [N_WSPR];
  word_t aspr_q [N_ASPR];

  ////////////////////////////////////////////////////////////
  // Load from write-back, one word per register type
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_WSPR; i++) begin
        wspr_q[i] <= '0;
      end
      for (int i = 0; i < N_ASPR; i++) begin
        aspr_q[i] <= '0;
      end
    end else begin
      if (wspr_we_i) begin
        wspr_q[wspr_wr_idx_i] <= wdata_i;
      end
      if (aspr_we_i) begin
        aspr_q[aspr_wr_idx_i] <= wdata_i;
      end
    end
  end

  // Asynchronous read for the dot product
  assign wspr_o = wspr_q[wspr_rd_idx_i];
  assign aspr_o = aspr_q[aspr_rd_idx_i];

endmodule

//--- rtl/ex_stage.sv
module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  alu_op_e   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,
  input  logic      mult_en_i,
  input  mult_op_e  mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  input  word_t     mult_operand_c_i,
  input  logic      dot_spr_operand_i,
  input  wspr_idx_t wspr_idx_i,
  input  aspr_idx_t aspr_idx_i,
  input  logic      wspr_load_i,
  input  logic      aspr_load_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  output logic      mult_multicycle_o
);

  word_t     alu_result, mac_result, dot_result, wspr_rd, aspr_rd;
  logic      mult_start, mult_load, mult_step, mult_done, mult_ready;
  logic      we_wb_q, wspr_load_wb_q, aspr_load_wb_q;
  reg_addr_t waddr_wb_q;
  wspr_idx_t wspr_idx_wb_q;
  aspr_idx_t aspr_idx_wb_q;

  assign mult_start = mult_en_i & (mult_operator_i == MULT_MAC);

  ex_alu i_alu (.operator_i(alu_operator_i), .operand_a_i(alu_operand_a_i),
    .operand_b_i(alu_operand_b_i), .result_o(alu_result), .cmp_result_o(branch_decision_o));

  mult_ctrl i_mult_ctrl (.clk, .rst_n, .start_i(mult_start), .count_done_i(mult_done),
    .ex_ready_i(ex_ready_o), .load_o(mult_load), .step_o(mult_step),
    .ready_o(mult_ready), .multicycle_o(mult_multicycle_o));

  mult_counter i_mult_counter (.clk, .rst_n, .load_i(mult_load), .step_i(mult_step),
    .done_o(mult_done));

  mult_datapath i_mult_datapath (.clk, .rst_n, .load_i(mult_load), .step_i(mult_step),
    .op_a_i(mult_operand_a_i), .op_b_i(mult_operand_b_i), .op_c_i(mult_operand_c_i),
    .result_o(mac_result));

  dot_unit i_dot_unit (.use_spr_i(dot_spr_operand_i), .op_a_i(mult_operand_a_i),
    .op_b_i(mult_operand_b_i), .op_c_i(mult_operand_c_i), .wspr_i(wspr_rd),
    .aspr_i(aspr_rd), .result_o(dot_result));

  rnn_spr_file i_spr_file (.clk, .rst_n, .wspr_rd_idx_i(wspr_idx_i), .aspr_rd_idx_i(aspr_idx_i),
    .wspr_we_i(we_wb_q & wspr_load_wb_q), .aspr_we_i(we_wb_q & aspr_load_wb_q),
    .wspr_wr_idx_i(wspr_idx_wb_q), .aspr_wr_idx_i(aspr_idx_wb_q), .wdata_i(lsu_rdata_i),
    .wspr_o(wspr_rd), .aspr_o(aspr_rd));

  ////////////////////////////////////////////////////////////
  // Forward port and branch outputs
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wdata_fw_o = csr_access_i ? csr_rdata_i                     // CSR first
                                : mult_en_i    ? (mult_start ? mac_result : dot_result)
                                : alu_result;
  assign jump_target_o = alu_operand_c_i;

  ////////////////////////////////////////////////////////////
  // EX/WB register and load write-back
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_wb_q        <= 1'b0;
      wspr_load_wb_q <= 1'b0;
      aspr_load_wb_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_wb_q        <= regfile_we_i & ~lsu_err_i; // Bus error kills the load
      wspr_load_wb_q <= wspr_load_i;
      aspr_load_wb_q <= aspr_load_i;
    end else if (wb_ready_i) begin
      we_wb_q <= 1'b0; // Bubble
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) begin
      waddr_wb_q    <= regfile_waddr_i;
      wspr_idx_wb_q <= wspr_idx_i;
      aspr_idx_wb_q <= aspr_idx_i;
    end
  end

  assign regfile_we_wb_o    = we_wb_q;
  assign regfile_waddr_wb_o = waddr_wb_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branches can retire without WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

//--- testbench/ex_stage_sva.sv
module ex_stage_sva (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,
  input logic ex_ready_i,
  input logic we_wb_i,
  input logic multicycle_i,
  input logic branch_in_ex_i
);

  // Stage only issues when it can also advance
  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> ex_ready_i)
    else $error("ex_valid_o high while ex_ready_o low");

  // Write-back follows an accepted instruction
  wb_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
    we_wb_i |-> $past(ex_valid_i))
    else $error("regfile_we_wb_o without ex_valid_o in the cycle before");

  ////////////////////////////////////////////////////////////
  // Multiply in flight blocks the stage
  ////////////////////////////////////////////////////////////

  mult_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (multicycle_i && !ex_ready_i && !branch_in_ex_i) |-> !ex_valid_i)
    else $error("ex_valid_o high during a stalled multiply");

endmodule

//--- testbench/tb_ex_stage.sv
module tb_ex_stage import ex_pkg::*; ();

  localparam int READY_TIMEOUT = 100;
  localparam int N_RANDOM      = 400;

  logic      clk, rst_n;
  logic      alu_en_i, mult_en_i, dot_spr_operand_i, wspr_load_i, aspr_load_i;
  logic      csr_access_i, lsu_en_i, lsu_ready_ex_i, lsu_err_i;
  logic      regfile_alu_we_i, regfile_we_i, branch_in_ex_i, wb_ready_i;
  alu_op_e   alu_operator_i;
  mult_op_e  mult_operator_i;
  word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  word_t     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  word_t     csr_rdata_i, lsu_rdata_i;
  wspr_idx_t wspr_idx_i;
  aspr_idx_t aspr_idx_i;
  reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic      regfile_alu_we_fw_o, regfile_we_wb_o, branch_decision_o;
  logic      ex_ready_o, ex_valid_o, mult_multicycle_o;
  reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  // Reference state for special registers and the pending write-back
  word_t     wspr_m [N_WSPR];
  word_t     aspr_m [N_ASPR];
  logic      pend_we, pend_wload, pend_aload;
  reg_addr_t pend_waddr;
  wspr_idx_t pend_widx;
  aspr_idx_t pend_aidx;
  string     test_name;
  string     kind_name [5] = '{"alu", "mac", "dot", "load", "csr"};

  ex_stage i_dut (.*);

  bind ex_stage ex_stage_sva i_sva (.clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid_o),
    .ex_ready_i(ex_ready_o), .we_wb_i(regfile_we_wb_o), .multicycle_i(mult_multicycle_o),
    .branch_in_ex_i(branch_in_ex_i));

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_SLT, ALU_LT:   return int'(a) < int'(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return int'(a) >= int'(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'(int'(a) >>> b[4:0]);
      default: return word_t'(cmp_model(op, a, b));
    endcase
  endfunction

  function automatic word_t dot_model(word_t a, word_t b, word_t c);
    int acc;
    acc = int'(c);
    for (int i = 0; i < DOT_LANES; i++) begin
      acc += int'($signed(a[i*LANE_W +: LANE_W])) * int'($signed(b[i*LANE_W +: LANE_W]));
    end
    return word_t'(acc);
  endfunction

  function automatic logic coin();
    return $urandom_range(0, 1) == 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Kinds: 0 ALU, 1 MAC, 2 dot product, 3 load, 4 CSR read
  task automatic drive_random(input int kind);
    alu_en_i            = (kind == 0) || ((kind == 4) && coin());
    mult_en_i           = (kind == 1) || (kind == 2) || ((kind == 4) && coin());
    lsu_en_i            = (kind == 3);
    csr_access_i        = (kind == 4);
    alu_operator_i      = alu_op_e'($urandom_range(0, 15));
    mult_operator_i     = (kind == 1) ? MULT_MAC : MULT_DOT8;
    alu_operand_a_i     = $urandom;
    alu_operand_b_i     = $urandom;
    alu_operand_c_i     = $urandom;
    mult_operand_a_i    = $urandom;
    mult_operand_b_i    = $urandom;
    mult_operand_c_i    = $urandom;
    dot_spr_operand_i   = coin();
    wspr_idx_i          = wspr_idx_t'($urandom_range(0, 3));
    aspr_idx_i          = aspr_idx_t'($urandom_range(0, 1));
    wspr_load_i         = lsu_en_i & coin();
    aspr_load_i         = lsu_en_i & coin();
    csr_rdata_i         = $urandom;
    lsu_rdata_i         = $urandom;
    lsu_err_i           = lsu_en_i & ($urandom_range(0, 3) == 0);
    regfile_alu_we_i    = coin();
    regfile_alu_waddr_i = reg_addr_t'($urandom);
    regfile_we_i        = lsu_en_i;
    regfile_waddr_i     = reg_addr_t'($urandom);
    branch_in_ex_i      = alu_en_i & coin();
  endtask

  task automatic issue(input int kind);
    word_t exp_fw;
    int    edges;
    @(negedge clk);
    drive_random(kind);
    test_name = kind_name[kind];
    #10;
    if (kind == 1) begin
      exp_fw = mult_operand_a_i * mult_operand_b_i + mult_operand_c_i;
    end else if (kind == 2) begin
      exp_fw = dot_model(dot_spr_operand_i ? wspr_m[wspr_idx_i] : mult_operand_a_i,
                         dot_spr_operand_i ? aspr_m[aspr_idx_i] : mult_operand_b_i,
                         mult_operand_c_i);
    end else if (kind == 4) begin
      exp_fw = csr_rdata_i; // Wins over any other enable
    end else begin
      exp_fw = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    end
    check_bit("fw enable", regfile_alu_we_i, regfile_alu_we_fw_o);
    check_addr("fw address", regfile_alu_waddr_i, regfile_alu_waddr_fw_o);
    check_bit("branch", cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
              branch_decision_o);
    check_word("jump target", alu_operand_c_i, jump_target_o);
    check_bit("wb enable", pend_we, regfile_we_wb_o);
    if (pend_we) begin
      check_addr("wb address", pend_waddr, regfile_waddr_wb_o);
      check_word("wb data", lsu_rdata_i, regfile_wdata_wb_o);
    end
    // Registers take the load at the edge closing this cycle
    if (pend_we && pend_wload) wspr_m[pend_widx] = lsu_rdata_i;
    if (pend_we && pend_aload) aspr_m[pend_aidx] = lsu_rdata_i;
    edges = 0;
    while (!ex_ready_o) begin
      if (edges > READY_TIMEOUT) begin
        $display("Timeout: ex_ready_o stayed low in test %s", test_name);
        abort_run();
      end
      if (edges > 0) check_bit("multicycle", 1'b1, mult_multicycle_o);
      @(posedge clk);
      edges++;
      @(negedge clk);
      #10;
    end
    if (kind == 1 && edges != MULT_STEPS + 2) begin // Sampling edge plus 33
      $display("Error: %s ready edges expected %0d actual %0d", test_name,
               MULT_STEPS + 2, edges);
      abort_run();
    end
    check_bit("multicycle", kind == 1, mult_multicycle_o);
    check_bit("ex_valid", 1'b1, ex_valid_o);
    check_word("fw data", exp_fw, regfile_alu_wdata_fw_o);
    pend_we    = regfile_we_i & ~lsu_err_i;
    pend_waddr = regfile_waddr_i;
    pend_wload = wspr_load_i;
    pend_aload = aspr_load_i;
    pend_widx  = wspr_idx_i;
    pend_aidx  = aspr_idx_i;
    @(posedge clk);
  endtask

  initial begin
    word_t exp_mac;
    void'($urandom(32'hceeb_5dd1));
    clk            = 1'b0;
    rst_n          = 1'b0;
    lsu_ready_ex_i = 1'b1;
    wb_ready_i     = 1'b1;
    drive_random(0);
    alu_en_i       = 1'b0;
    wspr_m         = '{default: '0};
    aspr_m         = '{default: '0};
    pend_we        = 1'b0;
    test_name      = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #10;
    check_bit("wb enable", 1'b0, regfile_we_wb_o);
    check_bit("multicycle", 1'b0, mult_multicycle_o);
    check_bit("ex_valid", 1'b0, ex_valid_o);

    for (int n = 0; n < N_RANDOM; n++) begin
      issue($urandom_range(0, 4));
    end

    ////////////////////////////////////////////////////////////
    // Multiply held in DONE while write-back stalls
    ////////////////////////////////////////////////////////////
    issue(0); // Empties the write-back slot
    @(negedge clk);
    drive_random(1);
    wb_ready_i = 1'b0;
    test_name  = "backpressure";
    exp_mac    = mult_operand_a_i * mult_operand_b_i + mult_operand_c_i;
    for (int i = 0; i < MULT_STEPS + 6; i++) begin
      #10;
      check_bit("ex_ready", 1'b0, ex_ready_o);
      check_bit("ex_valid", 1'b0, ex_valid_o);
      if (i >= MULT_STEPS + 2) check_word("held result", exp_mac, regfile_alu_wdata_fw_o);
      @(negedge clk);
    end
    wb_ready_i = 1'b1;
    #10;
    check_bit("ex_ready", 1'b1, ex_ready_o);
    check_bit("ex_valid", 1'b1, ex_valid_o);
    check_word("released result", exp_mac, regfile_alu_wdata_fw_o);
    @(posedge clk);
    pend_we = 1'b0;
    issue(2);

    @(negedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- ex_stage.f
common/ex_pkg.sv
rtl/ex_alu.sv
mult/mult_ctrl.sv
mult/mult_counter.sv
mult/mult_datapath.sv
rtl/dot_unit.sv
rtl/rnn_spr_file.sv
rtl/ex_stage.sv
testbench/ex_stage_sva.sv
testbench/tb_ex_stage.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ex_stage
FLIST      = ex_stage.f
PASS_MSG   = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
